/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int addr_w = 64;            // byte address
    localparam int line_w = 512;           // 64-byte line
    localparam int word_w = 64;            // cpu word

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int words_per_line = 8;
    localparam int offset_w = 6;           // byte offset within a line
    localparam int word_sel_w = 3;         // addr[5:3]

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cache geometry, same for both caches
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int num_lines = 16;
    localparam int index_w = 4;            // addr[9:6]
    localparam int tag_w = 54;             // addr[63:10]

endpackage

`default_nettype wire

/* src/cache_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_arbiter (
    input  logic                       clk,
    input  logic                       rst_n,

    // instruction cache side
    input  logic                       icache_req,
    input  logic [mem_pkg::addr_w-1:0] icache_address,
    output logic [mem_pkg::line_w-1:0] icache_rdata,
    output logic                       icache_complete,

    // data cache side
    input  logic                       dcache_req,
    input  logic [mem_pkg::addr_w-1:0] dcache_address,
    input  logic                       dcache_wr_en,
    input  logic [mem_pkg::line_w-1:0] dcache_wdata,
    output logic [mem_pkg::line_w-1:0] dcache_rdata,
    output logic                       dcache_complete,

    // memory controller
    output logic                       mem_req,
    output logic [mem_pkg::addr_w-1:0] mem_address,
    output logic                       mem_wr_en,
    output logic [mem_pkg::line_w-1:0] mem_wdata,
    input  logic                       mem_data_valid,
    input  logic [mem_pkg::line_w-1:0] mem_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_icache,     // waiting on memory for icache
        st_dcache,     // waiting on memory for dcache
        st_done        // owner sees complete, its req is still up
    } state_t;

    state_t state;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // grant control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= st_idle;
            mem_req         <= 1'b0;
            mem_wr_en       <= 1'b0;
            icache_complete <= 1'b0;
            dcache_complete <= 1'b0;
        end else begin
            mem_req         <= 1'b0;    // single-cycle pulse
            icache_complete <= 1'b0;
            dcache_complete <= 1'b0;
            case (state)
                st_idle: begin
                    if (icache_req) begin           // icache has priority
                        state     <= st_icache;
                        mem_req   <= 1'b1;
                        mem_wr_en <= 1'b0;
                    end else if (dcache_req) begin
                        state     <= st_dcache;
                        mem_req   <= 1'b1;
                        mem_wr_en <= dcache_wr_en;
                    end
                end
                st_icache: if (mem_data_valid) begin
                    icache_complete <= 1'b1;
                    state           <= st_done;
                end
                st_dcache: if (mem_data_valid) begin
                    dcache_complete <= 1'b1;
                    state           <= st_done;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request fields and response lines
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            if (icache_req) begin
                mem_address <= icache_address;
                mem_wdata   <= '0;
            end else if (dcache_req) begin
                mem_address <= dcache_address;
                mem_wdata   <= dcache_wdata;
            end
        end
        if (mem_data_valid && state == st_icache)
            icache_rdata <= mem_rdata;
        if (mem_data_valid && state == st_dcache)
            dcache_rdata <= mem_rdata;  // write ack carries no data, harmless
    end

endmodule

`default_nettype wire

/* src/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  logic                       clk,
    input  logic                       rst_n,

    // fetch port
    input  logic                       if_req,
    input  logic [mem_pkg::addr_w-1:0] if_addr,
    output logic [mem_pkg::word_w-1:0] if_rdata,
    output logic                       if_ready,

    // to arbiter
    output logic                       icache_req,
    output logic [mem_pkg::addr_w-1:0] icache_address,
    input  logic [mem_pkg::line_w-1:0] icache_rdata,
    input  logic                       icache_complete
);

    typedef enum logic {
        st_lookup,
        st_refill
    } state_t;

    state_t state;

    logic [mem_pkg::line_w-1:0]     data_mem [mem_pkg::num_lines];
    logic [mem_pkg::tag_w-1:0]      tag_mem  [mem_pkg::num_lines];
    logic [mem_pkg::num_lines-1:0]  valid;

    logic [mem_pkg::index_w-1:0]    idx;
    logic [mem_pkg::tag_w-1:0]      tag;
    logic [mem_pkg::word_sel_w-1:0] sel;
    logic [mem_pkg::addr_w-1:0]     line_addr;
    logic [mem_pkg::word_w-1:0]     hit_word;
    logic                           hit;
    logic                           accept;

    // address split
    assign idx = if_addr[mem_pkg::offset_w +: mem_pkg::index_w];
    assign tag = if_addr[mem_pkg::offset_w + mem_pkg::index_w +: mem_pkg::tag_w];
    assign sel = if_addr[mem_pkg::offset_w - mem_pkg::word_sel_w +: mem_pkg::word_sel_w];
    assign line_addr = {if_addr[mem_pkg::addr_w-1:mem_pkg::offset_w],
                        {mem_pkg::offset_w{1'b0}}};

    assign hit_word = data_mem[idx][sel * mem_pkg::word_w +: mem_pkg::word_w];
    assign hit      = valid[idx] && (tag_mem[idx] == tag);
    assign accept   = (state == st_lookup) && if_req && !if_ready; // req still up in ready cycle

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup / refill control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_lookup;
            valid      <= '0;
            if_ready   <= 1'b0;
            icache_req <= 1'b0;
        end else begin
            if_ready <= 1'b0;
            case (state)
                st_lookup: if (accept) begin
                    if (hit) begin
                        if_ready <= 1'b1;
                    end else begin
                        icache_req <= 1'b1;
                        state      <= st_refill;
                    end
                end
                st_refill: if (icache_complete) begin
                    valid[idx] <= 1'b1;
                    icache_req <= 1'b0;
                    if_ready   <= 1'b1;
                    state      <= st_lookup;
                end
                default: state <= st_lookup;
            endcase
        end
    end

    // arrays and response word
    always_ff @(posedge clk) begin
        if (accept) begin
            if_rdata       <= hit_word;     // only used on a hit
            icache_address <= line_addr;
        end
        if (state == st_refill && icache_complete) begin
            data_mem[idx] <= icache_rdata;
            tag_mem[idx]  <= tag;
            if_rdata      <= icache_rdata[sel * mem_pkg::word_w +: mem_pkg::word_w];
        end
    end

endmodule

`default_nettype wire

/* src/dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  logic                       clk,
    input  logic                       rst_n,

    // load/store port
    input  logic                       d_req,
    input  logic                       d_we,
    input  logic [mem_pkg::addr_w-1:0] d_addr,
    input  logic [mem_pkg::word_w-1:0] d_wdata,
    output logic [mem_pkg::word_w-1:0] d_rdata,
    output logic                       d_ready,

    // to arbiter
    output logic                       dcache_req,
    output logic [mem_pkg::addr_w-1:0] dcache_address,
    output logic                       dcache_wr_en,
    output logic [mem_pkg::line_w-1:0] dcache_wdata,
    input  logic [mem_pkg::line_w-1:0] dcache_rdata,
    input  logic                       dcache_complete
);

    typedef enum logic [1:0] {
        st_lookup,
        st_writeback,   // dirty victim going out
        st_refill
    } state_t;

    state_t state;

    logic [mem_pkg::line_w-1:0]     data_mem [mem_pkg::num_lines];
    logic [mem_pkg::tag_w-1:0]      tag_mem  [mem_pkg::num_lines];
    logic [mem_pkg::num_lines-1:0]  valid;
    logic [mem_pkg::num_lines-1:0]  dirty;

    logic [mem_pkg::index_w-1:0]    idx;
    logic [mem_pkg::tag_w-1:0]      tag;
    logic [mem_pkg::word_sel_w-1:0] sel;
    logic [mem_pkg::addr_w-1:0]     line_addr;
    logic [mem_pkg::addr_w-1:0]     victim_addr;
    logic [mem_pkg::word_w-1:0]     hit_word;
    logic                           hit;
    logic                           victim_dirty;
    logic                           accept;

    // replace one word of a line
    function automatic logic [mem_pkg::line_w-1:0] merge_word(
        input logic [mem_pkg::line_w-1:0]     line,
        input logic [mem_pkg::word_sel_w-1:0] word_sel,
        input logic [mem_pkg::word_w-1:0]     word
    );
        logic [mem_pkg::line_w-1:0] merged;
        merged = line;
        for (int w = 0; w < mem_pkg::words_per_line; w++) begin
            if (w == int'(word_sel))
                merged[w * mem_pkg::word_w +: mem_pkg::word_w] = word;
        end
        return merged;
    endfunction

    // address split
    assign idx = d_addr[mem_pkg::offset_w +: mem_pkg::index_w];
    assign tag = d_addr[mem_pkg::offset_w + mem_pkg::index_w +: mem_pkg::tag_w];
    assign sel = d_addr[mem_pkg::offset_w - mem_pkg::word_sel_w +: mem_pkg::word_sel_w];
    assign line_addr   = {d_addr[mem_pkg::addr_w-1:mem_pkg::offset_w],
                          {mem_pkg::offset_w{1'b0}}};
    assign victim_addr = {tag_mem[idx], idx, {mem_pkg::offset_w{1'b0}}};

    assign hit_word     = data_mem[idx][sel * mem_pkg::word_w +: mem_pkg::word_w];
    assign hit          = valid[idx] && (tag_mem[idx] == tag);
    assign victim_dirty = valid[idx] && dirty[idx];
    assign accept       = (state == st_lookup) && d_req && !d_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup / write-back / refill control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= st_lookup;
            valid        <= '0;
            dirty        <= '0;
            d_ready      <= 1'b0;
            dcache_req   <= 1'b0;
            dcache_wr_en <= 1'b0;
        end else begin
            d_ready <= 1'b0;
            case (state)
                st_lookup: if (accept) begin
                    if (hit) begin
                        d_ready <= 1'b1;
                        if (d_we)
                            dirty[idx] <= 1'b1;
                    end else if (victim_dirty) begin
                        dcache_req   <= 1'b1;
                        dcache_wr_en <= 1'b1;
                        state        <= st_writeback;
                    end else begin
                        dcache_req   <= 1'b1;
                        dcache_wr_en <= 1'b0;
                        state        <= st_refill;
                    end
                end
                st_writeback: if (dcache_complete) begin
                    dcache_wr_en <= 1'b0;   // req stays up, refill read follows
                    state        <= st_refill;
                end
                st_refill: if (dcache_complete) begin
                    valid[idx] <= 1'b1;
                    dirty[idx] <= d_we;
                    dcache_req <= 1'b0;
                    d_ready    <= 1'b1;
                    state      <= st_lookup;
                end
                default: state <= st_lookup;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // arrays, request fields, load data
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (accept) begin
            if (hit) begin
                if (d_we)
                    data_mem[idx] <= merge_word(data_mem[idx], sel, d_wdata);
                else
                    d_rdata <= hit_word;
            end else if (victim_dirty) begin
                dcache_address <= victim_addr;
                dcache_wdata   <= data_mem[idx];
            end else begin
                dcache_address <= line_addr;
            end
        end
        if (state == st_writeback && dcache_complete)
            dcache_address <= line_addr;
        if (state == st_refill && dcache_complete) begin
            // store miss merges into the fresh line
            data_mem[idx] <= d_we ? merge_word(dcache_rdata, sel, d_wdata) : dcache_rdata;
            tag_mem[idx]  <= tag;
            if (!d_we)
                d_rdata <= dcache_rdata[sel * mem_pkg::word_w +: mem_pkg::word_w];
        end
    end

endmodule

`default_nettype wire

/* src/mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  logic                       clk,
    input  logic                       rst_n,

    // fetch port
    input  logic                       if_req,
    input  logic [mem_pkg::addr_w-1:0] if_addr,
    output logic [mem_pkg::word_w-1:0] if_rdata,
    output logic                       if_ready,

    // load/store port
    input  logic                       d_req,
    input  logic                       d_we,
    input  logic [mem_pkg::addr_w-1:0] d_addr,
    input  logic [mem_pkg::word_w-1:0] d_wdata,
    output logic [mem_pkg::word_w-1:0] d_rdata,
    output logic                       d_ready,

    // memory controller
    output logic                       mem_req,
    output logic [mem_pkg::addr_w-1:0] mem_address,
    output logic                       mem_wr_en,
    output logic [mem_pkg::line_w-1:0] mem_wdata,
    input  logic                       mem_data_valid,
    input  logic [mem_pkg::line_w-1:0] mem_rdata
);

    // icache to arbiter
    logic                       icache_req;
    logic [mem_pkg::addr_w-1:0] icache_address;
    logic [mem_pkg::line_w-1:0] icache_rdata;
    logic                       icache_complete;

    // dcache to arbiter
    logic                       dcache_req;
    logic [mem_pkg::addr_w-1:0] dcache_address;
    logic                       dcache_wr_en;
    logic [mem_pkg::line_w-1:0] dcache_wdata;
    logic [mem_pkg::line_w-1:0] dcache_rdata;
    logic                       dcache_complete;

    icache u_icache (
        .clk, .rst_n,
        .if_req, .if_addr, .if_rdata, .if_ready,
        .icache_req, .icache_address, .icache_rdata, .icache_complete
    );

    dcache u_dcache (
        .clk, .rst_n,
        .d_req, .d_we, .d_addr, .d_wdata, .d_rdata, .d_ready,
        .dcache_req, .dcache_address, .dcache_wr_en, .dcache_wdata,
        .dcache_rdata, .dcache_complete
    );

    cache_arbiter u_arbiter (
        .clk, .rst_n,
        .icache_req, .icache_address, .icache_rdata, .icache_complete,
        .dcache_req, .dcache_address, .dcache_wr_en, .dcache_wdata,
        .dcache_rdata, .dcache_complete,
        .mem_req, .mem_address, .mem_wr_en, .mem_wdata,
        .mem_data_valid, .mem_rdata
    );

endmodule

`default_nettype wire

/* bench/mem_subsystem_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_chk (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       mem_req,
    input  logic                       mem_data_valid,
    input  logic [mem_pkg::addr_w-1:0] mem_address,
    input  logic                       mem_wr_en,
    input  logic [mem_pkg::line_w-1:0] mem_wdata,
    input  logic                       icache_complete,
    input  logic                       dcache_complete,
    input  logic                       if_ready,
    input  logic                       d_ready
);

    logic outstanding;  // between mem_req and mem_data_valid
    int   failures = 0; // failed assertions so far

    always_ff @(posedge clk) begin
        if (!rst_n)
            outstanding <= 1'b0;
        else if (mem_req)
            outstanding <= 1'b1;
        else if (mem_data_valid)
            outstanding <= 1'b0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    req_pulse: assert property (@(posedge clk) disable iff (!rst_n) mem_req |=> !mem_req)
        else begin
            $error("mem_req high for more than one cycle");
            failures++;
        end
    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> !outstanding)
        else begin
            $error("second mem_req before mem_data_valid");
            failures++;
        end
    fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding |-> $stable(mem_address) && $stable(mem_wr_en) && $stable(mem_wdata))
        else begin
            $error("memory request fields changed while outstanding");
            failures++;
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cache and cpu side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    one_complete: assert property (@(posedge clk) disable iff (!rst_n)
        !(icache_complete && dcache_complete))
        else begin
            $error("both caches completed in the same cycle");
            failures++;
        end
    if_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n) if_ready |=> !if_ready)
        else begin
            $error("if_ready high for more than one cycle");
            failures++;
        end
    d_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n) d_ready |=> !d_ready)
        else begin
            $error("d_ready high for more than one cycle");
            failures++;
        end
    reset_quiet: assert property (@(posedge clk) $rose(rst_n) |->
        !mem_req && !icache_complete && !dcache_complete && !if_ready && !d_ready)
        else begin
            $error("outputs not cleared by reset");
            failures++;
        end

endmodule

bind mem_subsystem mem_subsystem_chk u_chk (
    .clk, .rst_n, .mem_req, .mem_data_valid, .mem_address, .mem_wr_en, .mem_wdata,
    .icache_complete, .dcache_complete, .if_ready, .d_ready
);

`default_nettype wire

/* bench/mem_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

    localparam int          timeout_cycles = 200;
    localparam int          num_ops        = 400;
    localparam logic [63:0] seed           = 64'd76672;
    localparam logic [63:0] ibase          = 64'h0000_0000_0080_0000;  // only fetched from
    localparam logic [63:0] dbase          = 64'h0000_0000_0010_0000;

    logic                       clk;
    logic                       rst_n = 1'b0;
    logic                       if_req = 1'b0;
    logic [mem_pkg::addr_w-1:0] if_addr = '0;
    logic [mem_pkg::word_w-1:0] if_rdata;
    logic                       if_ready;
    logic                       d_req = 1'b0;
    logic                       d_we = 1'b0;
    logic [mem_pkg::addr_w-1:0] d_addr = '0;
    logic [mem_pkg::word_w-1:0] d_wdata = '0;
    logic [mem_pkg::word_w-1:0] d_rdata;
    logic                       d_ready;
    logic                       mem_req;
    logic [mem_pkg::addr_w-1:0] mem_address;
    logic                       mem_wr_en;
    logic [mem_pkg::line_w-1:0] mem_wdata;
    logic                       mem_data_valid = 1'b0;
    logic [mem_pkg::line_w-1:0] mem_rdata = '0;

    logic [mem_pkg::line_w-1:0]    mem_lines [logic [63:0]];  // backing store
    logic [63:0]                   ref_words [logic [63:0]];  // what the cpu must see
    logic [63:0]                   log_addr [$];              // every mem_req in order
    logic                          log_wr [$];
    logic [63:0]                   stim_rng = seed;
    logic [63:0]                   lat_rng = ~seed;
    int                            lat_cnt = 0;
    int                            errors = 0;
    int                            ops = 0;
    // lines the caches should hold right now
    logic [mem_pkg::tag_w-1:0]     itag [mem_pkg::num_lines];
    logic [mem_pkg::tag_w-1:0]     dtag [mem_pkg::num_lines];
    logic [mem_pkg::num_lines-1:0] ivalid = '0;
    logic [mem_pkg::num_lines-1:0] dvalid = '0;
    logic [mem_pkg::num_lines-1:0] ddirty = '0;

    mem_subsystem dut (
        .clk, .rst_n, .if_req, .if_addr, .if_rdata, .if_ready,
        .d_req, .d_we, .d_addr, .d_wdata, .d_rdata, .d_ready,
        .mem_req, .mem_address, .mem_wr_en, .mem_wdata, .mem_data_valid, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 7);
        s = s ^ (s << 17);
        return s;
    endfunction

    function automatic logic [63:0] init_word(input logic [63:0] a);
        return (a * 64'h9e37_79b9_7f4a_7c15) ^ 64'ha5a5_0f0f_3c3c_f00d;
    endfunction

    function automatic logic [63:0] ref_word(input logic [63:0] a);
        return ref_words.exists(a) ? ref_words[a] : init_word(a);
    endfunction

    function automatic logic [mem_pkg::line_w-1:0] read_line(input logic [63:0] line);
        logic [mem_pkg::line_w-1:0] data;
        if (mem_lines.exists(line))
            return mem_lines[line];
        for (int w = 0; w < mem_pkg::words_per_line; w++)
            data[w * mem_pkg::word_w +: mem_pkg::word_w] = init_word(line + 64'(w * 8));
        return data;
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("[ERROR] %0t %s: expected %h, got %h", $time, sig, expected, actual);
        errors++;
    endtask

    task automatic finish_run();
        $display("%0d errors and %0d protocol errors over %0d operations",
                 errors, dut.u_chk.failures, ops);
        if (errors == 0 && dut.u_chk.failures == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory controller model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin : mem_model
        logic [63:0] expected;
        #1;
        mem_data_valid = 1'b0;
        if (lat_cnt > 0) begin
            lat_cnt--;
            if (lat_cnt == 0) begin
                if (mem_wr_en)
                    mem_lines[mem_address] = mem_wdata;
                else
                    mem_rdata = read_line(mem_address);
                mem_data_valid = 1'b1;
            end
        end else if (rst_n && mem_req) begin
            lat_rng = xorshift(lat_rng);
            lat_cnt = 1 + int'(lat_rng % 64'd6);   // 1 to 6 cycles
            log_addr.push_back(mem_address);
            log_wr.push_back(mem_wr_en);
            for (int w = 0; w < mem_pkg::words_per_line && mem_wr_en; w++) begin
                expected = ref_word(mem_address + 64'(w * 8));
                assert (mem_wdata[w * mem_pkg::word_w +: mem_pkg::word_w] == expected)
                    else report_mismatch("mem_wdata", expected,
                                         mem_wdata[w * mem_pkg::word_w +: mem_pkg::word_w]);
            end
        end
    end

    task automatic fetch(input logic [63:0] addr);
        logic [mem_pkg::index_w-1:0] idx;
        logic [mem_pkg::tag_w-1:0]   tag;
        logic                        hit;
        int                          n;
        int                          n0;
        idx = addr[mem_pkg::offset_w +: mem_pkg::index_w];
        tag = addr[mem_pkg::addr_w-1 -: mem_pkg::tag_w];
        hit = ivalid[idx] && itag[idx] == tag;
        n0  = log_addr.size();
        n   = 0;
        @(posedge clk);
        #1;
        if_req  = 1'b1;
        if_addr = addr;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!if_ready && n < timeout_cycles);
        if_req = 1'b0;
        ops++;
        if (!if_ready) begin
            $display("%0t: fetch of %h got no if_ready within %0d cycles", $time, addr, n);
            errors++;
        end else begin
            assert (if_rdata == ref_word(addr))
                else report_mismatch("if_rdata", ref_word(addr), if_rdata);
            if (hit) begin
                assert (n == 1) else report_mismatch("if_ready latency", 64'd1, 64'(n));
                assert (log_addr.size() == n0)
                    else report_mismatch("mem_req count", 64'(n0), 64'(log_addr.size()));
            end
            ivalid[idx] = 1'b1;
            itag[idx]   = tag;
        end
    endtask

    task automatic access(input logic we, input logic [63:0] addr, input logic [63:0] data);
        logic [mem_pkg::index_w-1:0] idx;
        logic [mem_pkg::tag_w-1:0]   tag;
        logic [63:0]                 line;
        logic [63:0]                 victim;
        logic                        hit;
        logic                        dirty;
        int                          n;
        int                          n0;
        int                          wi;
        int                          ri;
        int                          nw;
        idx    = addr[mem_pkg::offset_w +: mem_pkg::index_w];
        tag    = addr[mem_pkg::addr_w-1 -: mem_pkg::tag_w];
        line   = {addr[mem_pkg::addr_w-1:mem_pkg::offset_w], {mem_pkg::offset_w{1'b0}}};
        victim = {dtag[idx], idx, {mem_pkg::offset_w{1'b0}}};
        hit    = dvalid[idx] && dtag[idx] == tag;
        dirty  = !hit && dvalid[idx] && ddirty[idx];
        n0     = log_addr.size();
        n      = 0;
        wi     = -1;
        ri     = -1;
        nw     = 0;
        @(posedge clk);
        #1;
        d_req   = 1'b1;
        d_we    = we;
        d_addr  = addr;
        d_wdata = data;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!d_ready && n < timeout_cycles);
        d_req = 1'b0;
        ops++;
        if (!d_ready) begin
            $display("%0t: access to %h got no d_ready within %0d cycles", $time, addr, n);
            errors++;
        end else begin
            if (!we)
                assert (d_rdata == ref_word(addr))
                    else report_mismatch("d_rdata", ref_word(addr), d_rdata);
            for (int k = n0; k < log_addr.size(); k++) begin
                if (log_wr[k]) begin
                    nw++;
                    if (log_addr[k] == victim)
                        wi = k;
                end else if (log_addr[k] == line && ri < 0) begin
                    ri = k;
                end
            end
            if (hit) begin
                assert (n == 1) else report_mismatch("d_ready latency", 64'd1, 64'(n));
                assert (log_addr.size() == n0)
                    else report_mismatch("mem_req count", 64'(n0), 64'(log_addr.size()));
            end else begin
                assert (nw == int'(dirty))
                    else report_mismatch("write-back count", 64'(dirty), 64'(nw));
                assert (ri > wi && (wi >= 0) == dirty) else begin
                    $display("%0t: refill of %h missing or out of order with write-back of %h",
                             $time, line, victim);
                    errors++;
                end
            end
            if (we)
                ref_words[addr] = data;
            dvalid[idx] = 1'b1;
            dtag[idx]   = tag;
            ddirty[idx] = we || (hit && ddirty[idx]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : stimulus
        int          n0;
        logic [63:0] offs;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        fetch(ibase + 64'h08);                      // miss
        fetch(ibase + 64'h18);                      // hits the line just filled
        access(1'b1, dbase + 64'h10, 64'hdead_beef_0123_4567);
        access(1'b0, dbase + 64'h10, '0);
        access(1'b0, dbase + 64'h410, '0);          // evicts the dirty line
        access(1'b0, dbase + 64'h10, '0);           // refill of written-back data

        // both caches miss in the same cycle
        access(1'b1, dbase + 64'h88, 64'h1111_2222_3333_4444);
        n0 = log_addr.size();
        fork
            fetch(ibase + 64'h2c0);
            access(1'b1, dbase + 64'h488, 64'h5555_6666_7777_8888);
        join
        assert (log_addr[n0] == ibase + 64'h2c0 && !log_wr[n0])
            else report_mismatch("first mem_address", ibase + 64'h2c0, log_addr[n0]);

        for (int i = 0; i < num_ops; i++) begin
            stim_rng = xorshift(stim_rng);
            offs = (64'(stim_rng[21:16]) << mem_pkg::offset_w) + (64'(stim_rng[9:7]) << 3);
            if (stim_rng[1:0] == 2'd0)
                fetch(ibase + offs);
            else
                access(stim_rng[2], dbase + offs, {stim_rng[31:0], stim_rng[63:32]});
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* mem_subsystem.f */
src/mem_pkg.sv
src/cache_arbiter.sv
src/icache.sv
src/dcache.sv
src/mem_subsystem.sv
bench/mem_subsystem_chk.sv
bench/mem_subsystem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the mem_subsystem testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f mem_subsystem.f \
        --top-module mem_subsystem_tb --Mdir obj_dir -o mem_subsystem_sim; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/mem_subsystem_sim)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" <<< "$output"; then
    exit 0
fi
exit 1
